/* fc_event_subsystem.f */
+incdir+src
src/fc_pkg.sv
src/fc_irq_lines.sv
src/fc_event_fifo.sv
src/fc_irq_arbiter.sv
src/fc_cfg_regs.sv
src/fc_event_subsystem.sv
verif/fc_event_subsystem_chk.sv
verif/fc_event_subsystem_tb.sv

/* src/fc_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_cfg_regs (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  we_i,
    input  fc_pkg::cfg_addr_e     addr_i,
    input  logic [31:0]           wdata_i,
    input  logic [`FC_NB_IRQ-1:0] pending_i,
    input  fc_pkg::evt_id_t       last_evt_i,
    input  logic                  fetch_en_i,
    output logic [31:0]           rdata_o,
    output logic [`FC_NB_IRQ-1:0] mask_o,
    output logic [`FC_NB_IRQ-1:0] set_bits_o,
    output logic [`FC_NB_IRQ-1:0] clr_bits_o,
    output logic                  fetch_en_o
);

    localparam int NB_IRQ = `FC_NB_IRQ;

    logic [NB_IRQ-1:0] mask_q;
    logic              ctrl_fetch_q;
    logic              wr_set;
    logic              wr_clr;

    //****************************************
    // Write side
    //****************************************

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mask_q       <= '0;
            ctrl_fetch_q <= 1'b0;
        end else if (we_i) begin
            if (addr_i == fc_pkg::CFG_MASK) begin
                mask_q <= wdata_i[NB_IRQ-1:0];
            end
            if (addr_i == fc_pkg::CFG_CTRL) begin
                ctrl_fetch_q <= wdata_i[0];
            end
        end
    end

    // SET and CLEAR act only in the cycle of the write strobe
    assign wr_set     = we_i & (addr_i == fc_pkg::CFG_SET);
    assign wr_clr     = we_i & (addr_i == fc_pkg::CFG_CLEAR);
    assign set_bits_o = wr_set ? wdata_i[NB_IRQ-1:0] : '0;
    assign clr_bits_o = wr_clr ? wdata_i[NB_IRQ-1:0] : '0;

    //****************************************
    // Read side
    //****************************************

    always_comb begin
        rdata_o = '0;
        case (addr_i)
            fc_pkg::CFG_MASK:     rdata_o[NB_IRQ-1:0] = mask_q;
            fc_pkg::CFG_PENDING:  rdata_o[NB_IRQ-1:0] = pending_i;
            fc_pkg::CFG_EVT_DATA: rdata_o = 32'(last_evt_i);
            fc_pkg::CFG_CTRL:     rdata_o[0] = ctrl_fetch_q;
            default:              rdata_o = '0;   // SET and CLEAR read as zero
        endcase
    end

    assign mask_o = mask_q;

    // Core only fetches when both software and the pad agree
    assign fetch_en_o = ctrl_fetch_q & fetch_en_i;

endmodule

`default_nettype wire

/* src/fc_event_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_event_fifo (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            push_i,
    input  fc_pkg::evt_id_t push_data_i,
    input  logic            pop_i,
    output logic            fulln_o,
    output logic            valid_o,
    output fc_pkg::evt_id_t head_o
);

    localparam int DEPTH = `FC_EVT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fc_pkg::evt_id_t  mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             fulln_q;
    logic             push_ok;
    logic             pop_ok;

    // Pushes are dropped while the registered flag says full
    assign push_ok = push_i & fulln_q;
    assign pop_ok  = pop_i & (count_q != '0);

    assign count_d = count_q + CNT_W'(push_ok) - CNT_W'(pop_ok);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            fulln_q  <= 1'b1;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_d;
            fulln_q <= (count_d != CNT_W'(DEPTH));
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assign fulln_o = fulln_q;
    assign valid_o = (count_q != '0);
    assign head_o  = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

/* src/fc_event_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_event_subsystem (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [`FC_NB_IRQ-1:0] events_i,
    input  logic                  event_fifo_valid_i,
    input  fc_pkg::evt_id_t       event_fifo_data_i,
    output logic                  event_fifo_fulln_o,
    input  logic                  fetch_en_i,
    output logic                  fetch_en_o,
    output logic                  core_irq_req_o,
    output fc_pkg::irq_id_t       core_irq_id_o,
    input  logic                  core_irq_ack_i,
    input  fc_pkg::irq_id_t       core_irq_ack_id_i,
    input  logic                  cfg_we_i,
    input  fc_pkg::cfg_addr_e     cfg_addr_i,
    input  logic [31:0]           cfg_wdata_i,
    output logic [31:0]           cfg_rdata_o
);

    logic [`FC_NB_IRQ-1:0] mask;
    logic [`FC_NB_IRQ-1:0] set_bits;
    logic [`FC_NB_IRQ-1:0] clr_bits;
    logic [`FC_NB_IRQ-1:0] pending;
    logic                  line_valid;
    fc_pkg::irq_id_t       line_id;
    logic                  line_claim;
    fc_pkg::irq_id_t       line_claim_id;
    logic                  fifo_valid;
    logic                  evt_valid;
    fc_pkg::evt_id_t       evt_head;
    logic                  evt_pop;
    fc_pkg::evt_id_t       last_evt;

    // The FIFO interrupt obeys mask bit 26 like any other line
    assign evt_valid = fifo_valid & mask[`FC_EVT_IRQ_ID];

    fc_irq_lines u_irq_lines (
        .clk_i      ( clk_i         ),
        .arst_n_i   ( arst_n_i      ),
        .events_i   ( events_i      ),
        .mask_i     ( mask          ),
        .set_bits_i ( set_bits      ),
        .clr_bits_i ( clr_bits      ),
        .claim_i    ( line_claim    ),
        .claim_id_i ( line_claim_id ),
        .pending_o  ( pending       ),
        .valid_o    ( line_valid    ),
        .id_o       ( line_id       )
    );

    fc_event_fifo u_event_fifo (
        .clk_i       ( clk_i              ),
        .arst_n_i    ( arst_n_i           ),
        .push_i      ( event_fifo_valid_i ),
        .push_data_i ( event_fifo_data_i  ),
        .pop_i       ( evt_pop            ),
        .fulln_o     ( event_fifo_fulln_o ),
        .valid_o     ( fifo_valid         ),
        .head_o      ( evt_head           )
    );

    fc_irq_arbiter u_irq_arbiter (
        .clk_i           ( clk_i             ),
        .arst_n_i        ( arst_n_i          ),
        .line_valid_i    ( line_valid        ),
        .line_id_i       ( line_id           ),
        .evt_valid_i     ( evt_valid         ),
        .evt_head_i      ( evt_head          ),
        .ack_i           ( core_irq_ack_i    ),
        .ack_id_i        ( core_irq_ack_id_i ),
        .irq_req_o       ( core_irq_req_o    ),
        .irq_id_o        ( core_irq_id_o     ),
        .line_claim_o    ( line_claim        ),
        .line_claim_id_o ( line_claim_id     ),
        .evt_pop_o       ( evt_pop           ),
        .last_evt_o      ( last_evt          )
    );

    fc_cfg_regs u_cfg_regs (
        .clk_i      ( clk_i       ),
        .arst_n_i   ( arst_n_i    ),
        .we_i       ( cfg_we_i    ),
        .addr_i     ( cfg_addr_i  ),
        .wdata_i    ( cfg_wdata_i ),
        .pending_i  ( pending     ),
        .last_evt_i ( last_evt    ),
        .fetch_en_i ( fetch_en_i  ),
        .rdata_o    ( cfg_rdata_o ),
        .mask_o     ( mask        ),
        .set_bits_o ( set_bits    ),
        .clr_bits_o ( clr_bits    ),
        .fetch_en_o ( fetch_en_o  )
    );

endmodule

`default_nettype wire

/* src/fc_irq_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_irq_arbiter (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            line_valid_i,
    input  fc_pkg::irq_id_t line_id_i,
    input  logic            evt_valid_i,
    input  fc_pkg::evt_id_t evt_head_i,
    input  logic            ack_i,
    input  fc_pkg::irq_id_t ack_id_i,
    output logic            irq_req_o,
    output fc_pkg::irq_id_t irq_id_o,
    output logic            line_claim_o,
    output fc_pkg::irq_id_t line_claim_id_o,
    output logic            evt_pop_o,
    output fc_pkg::evt_id_t last_evt_o
);

    localparam fc_pkg::irq_id_t EVT_ID = fc_pkg::irq_id_t'(`FC_EVT_IRQ_ID);

    logic            irq_req_q;
    fc_pkg::irq_id_t irq_id_q;
    fc_pkg::evt_id_t last_evt_q;
    logic            evt_wins;
    logic            win_valid;
    fc_pkg::irq_id_t win_id;
    logic            ack_is_evt;

    //****************************************
    // Winner selection
    //****************************************

    // Higher ID wins, the FIFO competes as line 26
    assign evt_wins  = evt_valid_i & (~line_valid_i | (line_id_i < EVT_ID));
    assign win_valid = line_valid_i | evt_valid_i;
    assign win_id    = evt_wins ? EVT_ID : line_id_i;

    //****************************************
    // Ack handling
    //****************************************

    assign ack_is_evt = (ack_id_i == EVT_ID);

    // Claiming a line that is not pending clears nothing
    assign line_claim_o    = ack_i & ~ack_is_evt;
    assign line_claim_id_o = ack_id_i;

    // An ack for an empty FIFO is ignored
    assign evt_pop_o = ack_i & ack_is_evt & evt_valid_i;

    //****************************************
    // Core request register
    //****************************************

    // The request drops on ack; the next edge is the idle cycle
    // where the updated sources are looked at again
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_req_q <= 1'b0;
            irq_id_q  <= '0;
        end else if (ack_i) begin
            irq_req_q <= 1'b0;
        end else if (!irq_req_q) begin
            irq_req_q <= win_valid;
            irq_id_q  <= win_id;
        end
    end

    // Popped event ID kept for software
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_evt_q <= '0;
        end else if (evt_pop_o) begin
            last_evt_q <= evt_head_i;
        end
    end

    assign irq_req_o  = irq_req_q;
    assign irq_id_o   = irq_id_q;
    assign last_evt_o = last_evt_q;

endmodule

`default_nettype wire

/* src/fc_irq_lines.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_irq_lines (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic [`FC_NB_IRQ-1:0] events_i,
    input  logic [`FC_NB_IRQ-1:0] mask_i,
    input  logic [`FC_NB_IRQ-1:0] set_bits_i,
    input  logic [`FC_NB_IRQ-1:0] clr_bits_i,
    input  logic                  claim_i,
    input  fc_pkg::irq_id_t       claim_id_i,
    output logic [`FC_NB_IRQ-1:0] pending_o,
    output logic                  valid_o,
    output fc_pkg::irq_id_t       id_o
);

    localparam int NB_IRQ = `FC_NB_IRQ;
    localparam int EVT_ID = `FC_EVT_IRQ_ID;

    logic [NB_IRQ-1:0] pending_q;
    logic [NB_IRQ-1:0] pending_d;
    logic [NB_IRQ-1:0] claim_mask;
    logic [NB_IRQ-1:0] masked;

    //****************************************
    // Pending register
    //****************************************

    // One-hot clear for the line the core just took
    always_comb begin
        claim_mask = '0;
        if (claim_i) begin
            claim_mask[claim_id_i] = 1'b1;
        end
    end

    // Lines are level sampled so a held line sets its bit again
    always_comb begin
        pending_d = (pending_q & ~clr_bits_i & ~claim_mask) | events_i | set_bits_i;
        pending_d[EVT_ID] = 1'b0;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
        end else begin
            pending_q <= pending_d;
        end
    end

    //****************************************
    // Highest masked pending line
    //****************************************

    assign masked = pending_q & mask_i;

    // Ascending scan, the last hit is the highest ID
    always_comb begin
        id_o = '0;
        for (int i = 0; i < NB_IRQ; i++) begin
            if (masked[i]) begin
                id_o = fc_pkg::irq_id_t'(i);
            end
        end
    end

    assign valid_o   = |masked;
    assign pending_o = pending_q;

endmodule

`default_nettype wire

/* src/fc_macros.svh */
`ifndef FC_MACROS_SVH
`define FC_MACROS_SVH

// Number of direct interrupt lines into the controller
`define FC_NB_IRQ 32

// Entries in the peripheral event FIFO
`define FC_EVT_FIFO_DEPTH 8

// Interrupt ID raised while the event FIFO holds data
// Line 26 of events_i is reserved for it
`define FC_EVT_IRQ_ID 26

`endif

/* src/fc_pkg.sv */
`default_nettype none

`include "fc_macros.svh"

package fc_pkg;

    // Interrupt ID as seen by the core
    typedef logic [$clog2(`FC_NB_IRQ)-1:0] irq_id_t;

    // Peripheral event ID from the event FIFO port
    typedef logic [7:0] evt_id_t;

    // Register map of the configuration port
    typedef enum logic [2:0] {
        CFG_MASK     = 3'd0,
        CFG_PENDING  = 3'd1,
        CFG_SET      = 3'd2,
        CFG_CLEAR    = 3'd3,
        CFG_EVT_DATA = 3'd4,
        CFG_CTRL     = 3'd5
    } cfg_addr_e;

endpackage

`default_nettype wire

/* verif/fc_event_subsystem_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_event_subsystem_chk (
    input logic                                       clk_i,
    input logic                                       arst_n_i,
    input logic                                       core_irq_req_o,
    input fc_pkg::irq_id_t                            core_irq_id_o,
    input logic                                       core_irq_ack_i,
    input logic                                       event_fifo_fulln_o,
    input logic [$clog2(`FC_EVT_FIFO_DEPTH+1)-1:0]    fifo_count_i
);

    localparam int DEPTH = `FC_EVT_FIFO_DEPTH;

    // Number of failed assertions
    int assert_errs = 0;

    no_req_after_reset: assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> !core_irq_req_o)
    else begin
        $error("core_irq_req_o high in the first cycle after reset");
        assert_errs++;
    end

    // The core sees one ID per request
    id_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        core_irq_req_o && !core_irq_ack_i |=> $stable(core_irq_id_o))
    else begin
        $error("core_irq_id_o changed while the request waited for ack");
        assert_errs++;
    end

    req_drops_on_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        core_irq_ack_i |=> !core_irq_req_o)
    else begin
        $error("core_irq_req_o still high in the cycle after an ack");
        assert_errs++;
    end

    // Full flag low exactly when all entries are used, never more
    fifo_flag: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ((!event_fifo_fulln_o) == (fifo_count_i == DEPTH)) && (fifo_count_i <= DEPTH))
    else begin
        $error("event_fifo_fulln_o does not match the stored count");
        assert_errs++;
    end

endmodule

`default_nettype wire

/* verif/fc_event_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fc_macros.svh"

module fc_event_subsystem_tb;

    localparam int          CLK_PERIOD  = 100;
    localparam int          RESET_CYC   = 16;
    localparam int          NB_IRQ      = `FC_NB_IRQ;
    localparam int          DEPTH       = `FC_EVT_FIFO_DEPTH;
    localparam int          EVT_ID      = `FC_EVT_IRQ_ID;
    localparam int          LINE_ROUNDS = 4;
    localparam int          SET_ROUNDS  = 3;
    localparam int          EVT_PUSHES  = 6;
    localparam int          OVF_PUSHES  = DEPTH + 3;
    // A line round may serve one request per line
    localparam int          NUM_OPS     = (LINE_ROUNDS + SET_ROUNDS) * NB_IRQ
                                          + (EVT_PUSHES + OVF_PUSHES) * 2 + 16;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;

    logic                  clk_i;
    logic                  arst_n_i;
    logic [NB_IRQ-1:0]     events_i;
    logic                  event_fifo_valid_i;
    fc_pkg::evt_id_t       event_fifo_data_i;
    logic                  event_fifo_fulln_o;
    logic                  fetch_en_i;
    logic                  fetch_en_o;
    logic                  core_irq_req_o;
    fc_pkg::irq_id_t       core_irq_id_o;
    logic                  core_irq_ack_i;
    fc_pkg::irq_id_t       core_irq_ack_id_i;
    logic                  cfg_we_i;
    fc_pkg::cfg_addr_e     cfg_addr_i;
    logic [31:0]           cfg_wdata_i;
    logic [31:0]           cfg_rdata_o;

    // Reference model
    logic [NB_IRQ-1:0]     model_pending;
    logic [NB_IRQ-1:0]     model_mask;
    logic                  model_ctrl;
    fc_pkg::evt_id_t       model_fifo[$];
    logic [31:0]           lfsr_q;
    logic                  req_seen;
    int                    errs;

    fc_event_subsystem u_fc_event_subsystem (.*);

    bind fc_event_subsystem fc_event_subsystem_chk u_chk (
        .clk_i              ( clk_i                ),
        .arst_n_i           ( arst_n_i             ),
        .core_irq_req_o     ( core_irq_req_o       ),
        .core_irq_id_o      ( core_irq_id_o        ),
        .core_irq_ack_i     ( core_irq_ack_i       ),
        .event_fifo_fulln_o ( event_fifo_fulln_o   ),
        .fifo_count_i       ( u_event_fifo.count_q )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //****************************************
    // Reference functions
    //****************************************

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
            val = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    // Lines allowed to request, the FIFO stands in for line 26
    function automatic logic [NB_IRQ-1:0] active_lines(input logic [NB_IRQ-1:0] pend,
                                                       input logic [NB_IRQ-1:0] mask,
                                                       input int fifo_cnt);
        logic [NB_IRQ-1:0] act;
        act = pend & mask;
        act[EVT_ID] = (fifo_cnt > 0) && mask[EVT_ID];
        return act;
    endfunction

    // Highest active ID wins
    function automatic fc_pkg::irq_id_t ref_id(input logic [NB_IRQ-1:0] pend,
                                               input logic [NB_IRQ-1:0] mask,
                                               input int fifo_cnt);
        logic [NB_IRQ-1:0] act;
        act = active_lines(pend, mask, fifo_cnt);
        for (int i = NB_IRQ - 1; i >= 0; i--) begin
            if (act[i]) begin
                return fc_pkg::irq_id_t'(i);
            end
        end
        return '0;
    endfunction

    //****************************************
    // Compare tasks
    //****************************************

    task automatic check_id(input string name, input fc_pkg::irq_id_t got,
                            input fc_pkg::irq_id_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            errs++;
        end
    endtask

    task automatic check_evt(input string name, input fc_pkg::evt_id_t got,
                             input fc_pkg::evt_id_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            errs++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            errs++;
        end
    endtask

    //****************************************
    // Drivers, the model moves on the edge the DUT samples
    //****************************************

    task automatic cfg_write(input fc_pkg::cfg_addr_e addr, input logic [31:0] data);
        @(posedge clk_i);
        cfg_we_i    <= 1'b1;
        cfg_addr_i  <= addr;
        cfg_wdata_i <= data;
        @(posedge clk_i);
        cfg_we_i <= 1'b0;
        case (addr)
            fc_pkg::CFG_MASK:  model_mask = data;
            fc_pkg::CFG_SET:   model_pending = model_pending | data;
            fc_pkg::CFG_CLEAR: model_pending = model_pending & ~data;
            fc_pkg::CFG_CTRL:  model_ctrl = data[0];
            default:           ;
        endcase
        model_pending[EVT_ID] = 1'b0;
    endtask

    task automatic cfg_read(input fc_pkg::cfg_addr_e addr, output logic [31:0] data);
        @(posedge clk_i);
        cfg_addr_i <= addr;
        @(negedge clk_i);
        data = cfg_rdata_o;
    endtask

    task automatic pulse_events(input logic [NB_IRQ-1:0] lines);
        @(posedge clk_i);
        events_i <= lines;
        @(posedge clk_i);
        events_i <= '0;
        model_pending = model_pending | lines;
        model_pending[EVT_ID] = 1'b0;
    endtask

    task automatic push_event(input fc_pkg::evt_id_t id);
        @(posedge clk_i);
        event_fifo_valid_i <= 1'b1;
        event_fifo_data_i  <= id;
        @(posedge clk_i);
        event_fifo_valid_i <= 1'b0;
        if (model_fifo.size() < DEPTH) begin
            model_fifo.push_back(id);
        end
        @(negedge clk_i);
        check_flag("event_fifo_fulln_o", event_fifo_fulln_o, model_fifo.size() != DEPTH);
    endtask

    // Core side ack, reads back the event ID after a FIFO pop
    task automatic take_irq(input fc_pkg::irq_id_t id);
        fc_pkg::evt_id_t popped;
        logic            did_pop;
        @(posedge clk_i);
        core_irq_ack_i    <= 1'b1;
        core_irq_ack_id_i <= id;
        cfg_addr_i        <= fc_pkg::CFG_EVT_DATA;
        @(posedge clk_i);
        core_irq_ack_i <= 1'b0;
        did_pop = 1'b0;
        popped  = '0;
        if (id == fc_pkg::irq_id_t'(EVT_ID)) begin
            if (model_fifo.size() > 0 && model_mask[EVT_ID]) begin
                popped  = model_fifo.pop_front();
                did_pop = 1'b1;
            end else begin
                $display("FIFO interrupt was requested while no event was stored");
                errs++;
            end
        end else begin
            model_pending[id] = 1'b0;
        end
        if (did_pop) begin
            @(negedge clk_i);
            check_evt("CFG_EVT_DATA", fc_pkg::evt_id_t'(cfg_rdata_o), popped);
        end
    endtask

    task automatic serve_all();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clk_i);
            if (core_irq_req_o) begin
                quiet = 0;
                take_irq(core_irq_id_o);
            end else begin
                quiet++;
            end
        end
        if (|active_lines(model_pending, model_mask, model_fifo.size())) begin
            $display("Request stayed low although an enabled interrupt is still pending");
            errs++;
        end
    endtask

    // Every new request must carry the model's winner
    always @(negedge clk_i) begin
        if (arst_n_i && core_irq_req_o && !req_seen) begin
            if (|active_lines(model_pending, model_mask, model_fifo.size())) begin
                check_id("core_irq_id_o", core_irq_id_o,
                         ref_id(model_pending, model_mask, model_fifo.size()));
            end else begin
                $display("core_irq_req_o rose with no enabled interrupt pending");
                errs++;
            end
        end
        req_seen <= core_irq_req_o;
    end

    initial begin
        #(CLK_PERIOD * (RESET_CYC + NUM_OPS * 40));
        $display("Watchdog expired, the test did not finish in %0d cycles",
                 RESET_CYC + NUM_OPS * 40);
        $display("Simulation failed");
        $finish;
    end

    //****************************************
    // Test sequence
    //****************************************

    initial begin
        logic [31:0] rd;
        logic [31:0] vec;
        int          asserts;
        arst_n_i           = 1'b0;
        events_i           = '0;
        event_fifo_valid_i = 1'b0;
        event_fifo_data_i  = '0;
        fetch_en_i         = 1'b0;
        core_irq_ack_i     = 1'b0;
        core_irq_ack_id_i  = '0;
        cfg_we_i           = 1'b0;
        cfg_addr_i         = fc_pkg::CFG_MASK;
        cfg_wdata_i        = '0;
        model_pending      = '0;
        model_mask         = '0;
        model_ctrl         = 1'b0;
        req_seen           = 1'b0;
        lfsr_q             = 32'h6b4;
        errs               = 0;
        repeat (RESET_CYC) @(posedge clk_i);
        arst_n_i <= 1'b1;

        @(negedge clk_i);
        check_flag("core_irq_req_o", core_irq_req_o, 1'b0);
        check_flag("fetch_en_o", fetch_en_o, 1'b0);
        check_flag("event_fifo_fulln_o", event_fifo_fulln_o, 1'b1);
        cfg_read(fc_pkg::CFG_MASK, rd);
        check_word("CFG_MASK", rd, 32'h0);

        // Random lines, disabled ones must stay pending
        for (int r = 0; r < LINE_ROUNDS; r++) begin
            vec = rand_bits(NB_IRQ);
            vec[EVT_ID] = 1'b0;
            cfg_write(fc_pkg::CFG_MASK, vec);
            vec = rand_bits(NB_IRQ);
            vec[EVT_ID] = 1'b0;
            pulse_events(vec);
            serve_all();
            cfg_read(fc_pkg::CFG_PENDING, rd);
            check_word("CFG_PENDING", rd, model_pending);
            cfg_write(fc_pkg::CFG_CLEAR, '1);
        end

        // Software set and clear
        for (int r = 0; r < SET_ROUNDS; r++) begin
            cfg_write(fc_pkg::CFG_MASK, rand_bits(NB_IRQ));
            cfg_write(fc_pkg::CFG_SET, rand_bits(NB_IRQ));
            cfg_read(fc_pkg::CFG_PENDING, rd);
            check_word("CFG_PENDING", rd, model_pending);
            cfg_write(fc_pkg::CFG_CLEAR, rand_bits(NB_IRQ));
            cfg_read(fc_pkg::CFG_PENDING, rd);
            check_word("CFG_PENDING", rd, model_pending);
            serve_all();
            cfg_write(fc_pkg::CFG_CLEAR, '1);
        end

        // Event FIFO in order, then overflow
        cfg_write(fc_pkg::CFG_MASK, 32'h1 << EVT_ID);
        for (int i = 0; i < EVT_PUSHES; i++) begin
            push_event(fc_pkg::evt_id_t'(rand_bits(8)));
        end
        serve_all();
        for (int i = 0; i < OVF_PUSHES; i++) begin
            push_event(fc_pkg::evt_id_t'(rand_bits(8)));
        end
        serve_all();
        check_flag("event_fifo_fulln_o", event_fifo_fulln_o, 1'b1);

        // Fetch enable gating
        for (int c = 0; c < 4; c++) begin
            cfg_write(fc_pkg::CFG_CTRL, 32'(c & 1));
            @(posedge clk_i);
            fetch_en_i <= c[1];
            @(negedge clk_i);
            check_flag("fetch_en_o", fetch_en_o, model_ctrl & c[1]);
            cfg_read(fc_pkg::CFG_CTRL, rd);
            check_word("CFG_CTRL", rd, {31'h0, model_ctrl});
        end

        repeat (4) @(posedge clk_i);
        asserts = u_fc_event_subsystem.u_chk.assert_errs;
        $display("Failed checks: %0d, failed assertions: %0d", errs, asserts);
        if (errs == 0 && asserts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
